/* common/fetch_pkg.sv */
package fetch_pkg;

    // Instruction virtual address
    typedef logic [39:0] addr_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Source of the next program counter
    typedef enum logic [1:0] {
        // Keep current PC
        NEXT_PC_SEL_PC     = 2'b00,
        // Sequential advance
        NEXT_PC_SEL_PC_4   = 2'b01,
        // PC sent back from commit
        NEXT_PC_SEL_COMMIT = 2'b10
    } next_pc_sel_t;

    // Exception causes
    // Numbering follows the privileged spec mcause codes
    // NONE takes a reserved code so it never aliases a real cause
    typedef enum logic [3:0] {
        MISALIGNED_FETCH    = 4'd0,
        INSTR_ACCESS_FAULT  = 4'd1,
        ILLEGAL_INSTR       = 4'd2,
        BREAKPOINT          = 4'd3,
        LD_ADDR_MISALIGNED  = 4'd4,
        LD_ACCESS_FAULT     = 4'd5,
        ST_ADDR_MISALIGNED  = 4'd6,
        ST_ACCESS_FAULT     = 4'd7,
        USER_ECALL          = 4'd8,
        SUPERVISOR_ECALL    = 4'd9,
        MACHINE_ECALL       = 4'd11,
        INSTR_PAGE_FAULT    = 4'd12,
        LD_PAGE_FAULT       = 4'd13,
        // Reserved slot, used for "no exception"
        NONE                = 4'd14,
        ST_PAGE_FAULT       = 4'd15
    } exc_cause_t;

    // Boot address
    localparam addr_t RESET_PC = 40'h00_0000_1000;

endpackage

/* icache/refill_counter.sv */
`timescale 1ns/1ps

module refill_counter #(
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,

    // Line request issued
    input  logic                          start_i,
    // Memory word strobe
    input  logic                          rvalid_i,

    output logic [$clog2(LINE_WORDS)-1:0] word_idx_o,
    output logic                          last_word_o
);

    localparam int IDX_W = $clog2(LINE_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LINE_WORDS - 1);

    logic             busy_q;
    logic [IDX_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q  <= 1'b0;
            count_q <= '0;
        end else if (start_i) begin
            // Words come back in ascending order from zero
            busy_q  <= 1'b1;
            count_q <= '0;
        end else if (busy_q && rvalid_i) begin
            count_q <= count_q + 1'b1;
            if (count_q == LAST_IDX) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign word_idx_o  = count_q;
    assign last_word_o = busy_q & rvalid_i & (count_q == LAST_IDX);

    // Memory sends exactly one line per request
    a_no_stray_rvalid: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        rvalid_i |-> busy_q
    ) else $error("refill_counter: rvalid with no refill pending");

endmodule

/* icache/icache_array.sv */
`timescale 1ns/1ps

module icache_array #(
    parameter int LINE_WORDS = 4,
    parameter int SETS       = 16
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,

    // Lookup address
    input  fetch_pkg::addr_t              pc_i,

    // Refill side
    input  logic                          refill_start_i,
    input  logic                          rvalid_i,
    input  logic                          last_word_i,
    input  logic [$clog2(LINE_WORDS)-1:0] word_idx_i,
    input  fetch_pkg::inst_t              rdata_i,

    output logic                          hit_o,
    output fetch_pkg::inst_t              inst_o,
    // Line address towards memory
    output fetch_pkg::addr_t              mem_addr_o
);

    import fetch_pkg::*;

    localparam int ADDR_W = $bits(addr_t);
    localparam int IDX_W  = $clog2(LINE_WORDS);
    // Byte offset within a line
    localparam int OFF_W  = IDX_W + 2;
    localparam int SET_W  = $clog2(SETS);
    localparam int TAG_W  = ADDR_W - OFF_W - SET_W;

    // Storage
    inst_t             data_q [SETS][LINE_WORDS];
    logic [TAG_W-1:0]  tag_q  [SETS];
    logic [SETS-1:0]   valid_q;

    // Line being refilled
    addr_t             line_addr_q;
    logic              line_pending_q;

    // Lookup fields
    logic [IDX_W-1:0]  pc_word;
    logic [SET_W-1:0]  pc_set;
    logic [TAG_W-1:0]  pc_tag;

    // Refill fields
    addr_t             start_line;
    logic [SET_W-1:0]  start_set;
    logic [SET_W-1:0]  line_set;
    logic [TAG_W-1:0]  line_tag;

    assign pc_word = pc_i[2 +: IDX_W];
    assign pc_set  = pc_i[OFF_W +: SET_W];
    assign pc_tag  = pc_i[ADDR_W-1 -: TAG_W];

    // Combinational hit and read
    assign hit_o  = valid_q[pc_set] & (tag_q[pc_set] == pc_tag);
    assign inst_o = data_q[pc_set][pc_word];

    assign start_line = {pc_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign start_set  = pc_i[OFF_W +: SET_W];
    assign line_set   = line_addr_q[OFF_W +: SET_W];
    assign line_tag   = line_addr_q[ADDR_W-1 -: TAG_W];

    // Request cycle sees the live PC, later cycles the latch
    assign mem_addr_o = refill_start_i ? start_line : line_addr_q;

    // Refill address latch
    always_ff @(posedge clk_i) begin
        if (refill_start_i) begin
            line_addr_q <= start_line;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            line_pending_q <= 1'b0;
        end else if (refill_start_i) begin
            line_pending_q <= 1'b1;
        end else if (last_word_i) begin
            line_pending_q <= 1'b0;
        end
    end

    // Data and tag write port
    always_ff @(posedge clk_i) begin
        if (rvalid_i) begin
            data_q[line_set][word_idx_i] <= rdata_i;
        end
        if (last_word_i) begin
            tag_q[line_set] <= line_tag;
        end
    end

    // Valid bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else begin
            // Victim line drops out while it is overwritten
            if (refill_start_i) begin
                valid_q[start_set] <= 1'b0;
            end
            if (last_word_i) begin
                valid_q[line_set] <= 1'b1;
            end
        end
    end

    // Every word written lands in a line that was requested
    a_write_has_line: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (rvalid_i | last_word_i) |-> line_pending_q
    ) else $error("icache_array: refill write with no latched line");

endmodule

/* hdl/if_stage.sv */
`timescale 1ns/1ps

module if_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    // Decode back-pressure
    input  logic                   stall_i,
    // Next PC source from the controller
    input  fetch_pkg::next_pc_sel_t next_pc_sel_i,
    // PC coming back from commit
    input  fetch_pkg::addr_t       redirect_pc_i,

    // Cache lookup result for the current PC
    input  logic                   hit_i,
    input  fetch_pkg::inst_t       inst_i,

    // Current PC towards cache and controller
    output fetch_pkg::addr_t       pc_o,
    output logic                   misaligned_o,

    // Packet to decode
    output logic                   fetch_valid_o,
    output fetch_pkg::addr_t       fetch_pc_o,
    output fetch_pkg::inst_t       fetch_inst_o,
    output logic                   fetch_ex_valid_o,
    output fetch_pkg::exc_cause_t  fetch_ex_cause_o
);

    import fetch_pkg::*;

    addr_t pc_q;
    addr_t next_pc;
    logic  misaligned;

    // Three-way next PC mux
    always_comb begin
        case (next_pc_sel_i)
            NEXT_PC_SEL_PC_4:   next_pc = pc_q + 40'd4;
            NEXT_PC_SEL_COMMIT: next_pc = redirect_pc_i;
            default:            next_pc = pc_q;
        endcase
    end

    // PC register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    // Only commit can bring in a PC with low bits set
    assign misaligned = |pc_q[1:0];

    assign pc_o         = pc_q;
    assign misaligned_o = misaligned;

    // Decode packet, same cycle as the lookup
    assign fetch_valid_o    = hit_i | misaligned;
    assign fetch_pc_o       = pc_q;
    // No instruction is returned for a faulting fetch
    assign fetch_inst_o     = misaligned ? '0 : inst_i;
    assign fetch_ex_valid_o = misaligned;
    assign fetch_ex_cause_o = misaligned ? MISALIGNED_FETCH : NONE;

    // Controller must park on a misaligned PC until the next redirect
    a_no_advance_misaligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        misaligned |-> (next_pc_sel_i != NEXT_PC_SEL_PC_4)
    ) else $error("if_stage: advance selected on misaligned PC");

    // Held packet keeps its PC while decode stalls
    a_stall_holds_pc: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (stall_i && next_pc_sel_i != NEXT_PC_SEL_COMMIT) |=> $stable(pc_q)
    ) else $error("if_stage: PC moved during stall");

endmodule

/* hdl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    // Decode back-pressure, level
    input  logic                    stall_i,
    // Commit redirect, single-cycle pulse
    input  logic                    redirect_valid_i,

    // Lookup status of the current PC
    input  logic                    hit_i,
    input  logic                    misaligned_i,

    // Final refill word strobe from the counter
    input  logic                    last_word_i,

    output fetch_pkg::next_pc_sel_t next_pc_sel_o,
    // Line request, also arms counter and address latch
    output logic                    refill_start_o
);

    import fetch_pkg::*;

    typedef enum logic {
        LOOKUP = 1'b0,
        REFILL = 1'b1
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   consume;
    logic   miss;

    // Packet leaves the stage this cycle
    // A hit on another line is usable even while a refill runs
    assign consume = hit_i & ~misaligned_i & ~stall_i;

    // Aligned miss that nothing else overrides
    assign miss = ~hit_i & ~misaligned_i & ~redirect_valid_i;

    // Next PC source
    always_comb begin
        if (redirect_valid_i) begin
            // Redirect wins over stall and miss
            next_pc_sel_o = NEXT_PC_SEL_COMMIT;
        end else if (consume) begin
            next_pc_sel_o = NEXT_PC_SEL_PC_4;
        end else begin
            next_pc_sel_o = NEXT_PC_SEL_PC;
        end
    end

    // Request goes out in the same cycle the miss is seen
    // Stall does not hold back a refill
    assign refill_start_o = (state_q == LOOKUP) & miss;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (refill_start_o) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // Line written at this edge, next cycle hits
                if (last_word_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    // Counter only finishes a line that this FSM is waiting for
    a_last_in_refill: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        last_word_i |-> (state_q == REFILL)
    ) else $error("fetch_ctrl: last word outside REFILL");

    // One outstanding line at a time
    a_single_refill: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        refill_start_o |=> (!refill_start_o until_with last_word_i)
    ) else $error("fetch_ctrl: second refill before last word");

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter int LINE_WORDS = 4,
    parameter int SETS       = 16
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    // Core control
    input  logic                   stall_i,
    input  logic                   redirect_valid_i,
    input  fetch_pkg::addr_t       redirect_pc_i,

    // Line memory
    output logic                   mem_req_o,
    output fetch_pkg::addr_t       mem_addr_o,
    input  logic                   mem_rvalid_i,
    input  fetch_pkg::inst_t       mem_rdata_i,

    // Decode packet
    output logic                   fetch_valid_o,
    output fetch_pkg::addr_t       fetch_pc_o,
    output fetch_pkg::inst_t       fetch_inst_o,
    output logic                   fetch_ex_valid_o,
    output fetch_pkg::exc_cause_t  fetch_ex_cause_o
);

    import fetch_pkg::*;

    localparam int IDX_W = $clog2(LINE_WORDS);

    addr_t            pc;
    logic             misaligned;
    logic             hit;
    inst_t            inst;
    next_pc_sel_t     next_pc_sel;
    logic             refill_start;
    logic [IDX_W-1:0] word_idx;
    logic             last_word;

    // Line request leaves as a single pulse
    assign mem_req_o = refill_start;

    if_stage if_stage_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_i),
        .next_pc_sel_i    (next_pc_sel),
        .redirect_pc_i    (redirect_pc_i),
        .hit_i            (hit),
        .inst_i           (inst),
        .pc_o             (pc),
        .misaligned_o     (misaligned),
        .fetch_valid_o    (fetch_valid_o),
        .fetch_pc_o       (fetch_pc_o),
        .fetch_inst_o     (fetch_inst_o),
        .fetch_ex_valid_o (fetch_ex_valid_o),
        .fetch_ex_cause_o (fetch_ex_cause_o)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .hit_i            (hit),
        .misaligned_i     (misaligned),
        .last_word_i      (last_word),
        .next_pc_sel_o    (next_pc_sel),
        .refill_start_o   (refill_start)
    );

    refill_counter #(
        .LINE_WORDS (LINE_WORDS)
    ) refill_counter_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .start_i     (refill_start),
        .rvalid_i    (mem_rvalid_i),
        .word_idx_o  (word_idx),
        .last_word_o (last_word)
    );

    icache_array #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) icache_array_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .pc_i           (pc),
        .refill_start_i (refill_start),
        .rvalid_i       (mem_rvalid_i),
        .last_word_i    (last_word),
        .word_idx_i     (word_idx),
        .rdata_i        (mem_rdata_i),
        .hit_o          (hit),
        .inst_o         (inst),
        .mem_addr_o     (mem_addr_o)
    );

endmodule

/* bench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int LINE_WORDS = 4,
    parameter int DELAY      = 3
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             req_i,
    input  fetch_pkg::addr_t addr_i,
    output logic             rvalid_o,
    // Address of the word now on the bus, the bench maps it to data
    output fetch_pkg::addr_t word_addr_o
);

    import fetch_pkg::*;

    addr_t line;

    initial begin
        rvalid_o    = 1'b0;
        word_addr_o = '0;
        forever begin
            @(posedge clk_i);
            if (rstn_i && req_i) begin
                line = addr_i;
                // First word is sampled DELAY edges after the request edge
                repeat (DELAY - 1) @(posedge clk_i);
                for (int w = 0; w < LINE_WORDS; w++) begin
                    #1;
                    rvalid_o    = 1'b1;
                    word_addr_o = line + addr_t'(4 * w);
                    @(posedge clk_i);
                end
                #1;
                rvalid_o = 1'b0;
            end
        end
    end

endmodule

/* bench/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

    import fetch_pkg::*;

    localparam int LINE_WORDS    = 4;
    localparam int SETS          = 16;
    localparam int OFF_W         = $clog2(LINE_WORDS) + 2;
    localparam int SET_W         = $clog2(SETS);
    // Directed phases plus the 300 packet mixed run, rounded up
    localparam int TOTAL_PACKETS = 375;
    // Each packet costs at most one refill of 8 cycles
    localparam int MAX_CYCLES    = TOTAL_PACKETS * 8;

    logic       clk;
    logic       rstn;
    logic       stall;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       mem_req;
    addr_t      mem_addr;
    logic       mem_rvalid;
    addr_t      mem_word_addr;
    inst_t      mem_rdata;
    logic       fetch_valid;
    addr_t      fetch_pc;
    inst_t      fetch_inst;
    logic       fetch_ex_valid;
    exc_cause_t fetch_ex_cause;

    // Reference model state
    addr_t            exp_pc;
    addr_t            tag_m [SETS];
    logic [SETS-1:0]  valid_m;
    logic             busy_m;
    int               words_m;
    logic [SET_W-1:0] fill_set;
    int               consumed = 0;
    // Line requests seen on the memory port
    int               reqs_seen = 0;
    int               reqs_before;
    int               cycles;
    integer           seed;

    // Memory contents
    function automatic inst_t inst_of(addr_t a);
        return a[31:0] ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic [SET_W-1:0] set_of(addr_t a);
        return a[OFF_W +: SET_W];
    endfunction

    function automatic addr_t line_of(addr_t a);
        return {a[$bits(addr_t)-1:OFF_W], {OFF_W{1'b0}}};
    endfunction

    assign mem_rdata = inst_of(mem_word_addr);

    fetch_top #(
        .LINE_WORDS (LINE_WORDS),
        .SETS       (SETS)
    ) fetch_top_i (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .stall_i          (stall),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .mem_req_o        (mem_req),
        .mem_addr_o       (mem_addr),
        .mem_rvalid_i     (mem_rvalid),
        .mem_rdata_i      (mem_rdata),
        .fetch_valid_o    (fetch_valid),
        .fetch_pc_o       (fetch_pc),
        .fetch_inst_o     (fetch_inst),
        .fetch_ex_valid_o (fetch_ex_valid),
        .fetch_ex_cause_o (fetch_ex_cause)
    );

    tb_mem_model #(
        .LINE_WORDS (LINE_WORDS),
        .DELAY      (3)
    ) mem_model_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_i       (mem_req),
        .addr_i      (mem_addr),
        .rvalid_o    (mem_rvalid),
        .word_addr_o (mem_word_addr)
    );

    task automatic stop_run(input string why);
        $display("sim failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run("address mismatch");
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run("instruction mismatch");
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_t got, input exc_cause_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %s, expected %s", $time, name, got.name(),
                     exp.name());
            stop_run("cause mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_run("flag mismatch");
        end
    endtask

    // Advance to just after the next rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic redirect_to(input addr_t pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        step();
        redirect_valid = 1'b0;
    endtask

    // Run until n more packets leave the stage
    task automatic run_packets(input int n, input int stall_pct, input int redir_pct);
        int target;
        target = consumed + n;
        while (consumed < target) begin
            if (($unsigned($random(seed)) % 100) < redir_pct) begin
                // Aligned target somewhere in the first 4 KiB of code
                redirect_pc    = RESET_PC + addr_t'(($unsigned($random(seed)) % 1024) * 4);
                redirect_valid = 1'b1;
            end
            stall = ($unsigned($random(seed)) % 100) < stall_pct;
            step();
            redirect_valid = 1'b0;
        end
        stall = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sampled at the falling edge, all inputs and outputs settled
    always @(negedge clk) begin : compare
        logic aligned;
        logic hit_m;
        logic exp_req;
        if (!rstn) begin
            exp_pc  = RESET_PC;
            valid_m = '0;
            busy_m  = 1'b0;
            words_m = 0;
            check_flag("fetch_valid_o", fetch_valid, 1'b0);
            check_flag("fetch_ex_valid_o", fetch_ex_valid, 1'b0);
        end else begin
            aligned = (exp_pc[1:0] == 2'b00);
            hit_m   = valid_m[set_of(exp_pc)] && (tag_m[set_of(exp_pc)] == line_of(exp_pc));
            // Request only from lookup, only for an aligned miss with no redirect
            exp_req = !busy_m && aligned && !redirect_valid && !hit_m;
            check_addr("fetch_pc_o", fetch_pc, exp_pc);
            check_flag("fetch_valid_o", fetch_valid, !aligned || hit_m);
            check_flag("fetch_ex_valid_o", fetch_ex_valid, !aligned);
            check_flag("mem_req_o", mem_req, exp_req);
            if (mem_req) begin
                reqs_seen++;
            end
            if (fetch_valid) begin
                check_cause("fetch_ex_cause_o", fetch_ex_cause,
                            aligned ? NONE : MISALIGNED_FETCH);
                check_inst("fetch_inst_o", fetch_inst, aligned ? inst_of(exp_pc) : '0);
            end
            if (exp_req) begin
                check_addr("mem_addr_o", mem_addr, line_of(exp_pc));
                // Victim line drops out until the new one is complete
                tag_m[set_of(exp_pc)]   = line_of(exp_pc);
                valid_m[set_of(exp_pc)] = 1'b0;
                fill_set                = set_of(exp_pc);
                busy_m                  = 1'b1;
                words_m                 = 0;
            end
            if (mem_rvalid) begin
                words_m++;
                if (words_m == LINE_WORDS) begin
                    valid_m[fill_set] = 1'b1;
                    busy_m            = 1'b0;
                end
            end
            // Expected PC for the next cycle
            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end else if (aligned && hit_m && !stall) begin
                exp_pc = exp_pc + 40'd4;
                consumed++;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", MAX_CYCLES);
        stop_run("timeout");
    end

    initial begin
        seed           = 63574;
        rstn           = 1'b0;
        stall          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        // Straight line code over several lines, then with stalls
        run_packets(20, 0, 0);
        run_packets(20, 30, 0);
        redirect_to(40'h2000);
        run_packets(6, 0, 0);
        // Second redirect lands while the 0x3000 line is still coming in
        redirect_to(40'h3000);
        step();
        redirect_to(40'h4000);
        run_packets(8, 0, 0);
        // Sets 4 and 5 still hold lines from the start, no refill expected
        reqs_before = reqs_seen;
        redirect_to(RESET_PC + 40'h40);
        run_packets(8, 0, 0);
        if (reqs_seen != reqs_before) begin
            $display("Memory request issued for a line that was still in the cache");
            stop_run("line reuse");
        end
        // Misaligned target parks the stage
        redirect_to(40'h1002);
        repeat (10) step();
        redirect_to(RESET_PC);
        run_packets(4, 0, 0);
        run_packets(300, 20, 3);
        $display("sim passed");
        $finish;
    end

endmodule

/* compile.f */
common/fetch_pkg.sv
icache/refill_counter.sv
icache/icache_array.sv
hdl/if_stage.sv
hdl/fetch_ctrl.sv
hdl/fetch_top.sv
bench/tb_mem_model.sv
bench/tb_fetch_top.sv
